// ==== src/router_settings.svh ====
`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// Flit word width
`define FLIT_WIDTH 32

// Packet length field, low bits of a header flit
`define LENGTH_WIDTH 12

// Flit kind field
`define FLIT_ID_MSB 31
`define FLIT_ID_LSB 29

`endif

// ==== src/routerPkg.sv ====
`include "router_settings.svh"

package routerPkg;

  // One flit word as it travels through the port
  typedef logic [`FLIT_WIDTH-1:0] flit_t;

  // Kind field of a flit, one-hot
  typedef enum logic [2:0]
  {
    flitHeader = 3'b001,
    flitBody   = 3'b010,
    flitTail   = 3'b100
  } flitId_t;

  // Grant cycles counted per packet
  typedef logic [`LENGTH_WIDTH-1:0] pktLength_t;

  // Arbiter state, also used as source port tag on the output
  typedef enum logic [5:0]
  {
    stIdle  = 6'b000001,
    stLocal = 6'b000010,
    stNorth = 6'b000100,
    stEast  = 6'b001000,
    stWest  = 6'b010000,
    stSouth = 6'b100000
  } arbState_t;

endpackage

// ==== src/flitDecoder.sv ====
`timescale 1ns/1ps
`include "router_settings.svh"

module flitDecoder (
  input  logic                   clk,
  input  logic                   rst,
  input  routerPkg::flit_t       inFlit,
  input  logic                   inValid,
  output logic                   req,
  output routerPkg::flitId_t     flitId,
  output routerPkg::pktLength_t  length,
  output routerPkg::flit_t       flitAligned,
  output logic                   validAligned
);

  import routerPkg::*;

  flit_t flitReg;  // Stage 1 word
  logic  validReg;

  // Stage 1 capture
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      validReg <= 1'b0;
    end
    else
    begin
      validReg <= inValid;
    end
  end

  always_ff @(posedge clk)
  begin
    flitReg <= inFlit;
  end

  // Decode fields from the stage 1 register
  assign req    = validReg;
  assign flitId = flitId_t'(flitReg[`FLIT_ID_MSB:`FLIT_ID_LSB]);
  assign length = flitReg[`LENGTH_WIDTH-1:0];  // Only meaningful on a header

  // Second stage lines the word up with the grant it causes
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      validAligned <= 1'b0;
    end
    else
    begin
      validAligned <= validReg;
    end
  end

  always_ff @(posedge clk)
  begin
    flitAligned <= flitReg;
  end

endmodule

// ==== src/grantTimer.sv ====
`timescale 1ns/1ps

module grantTimer (
  input  logic                   clk,
  input  logic                   rst,
  input  routerPkg::flitId_t     flitId,
  input  routerPkg::pktLength_t  length,
  input  logic                   runTimer,
  output logic                   timesUp
);

  import routerPkg::*;

  pktLength_t latchedLength;
  pktLength_t count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      latchedLength <= '0;
      count         <= '0;
    end
    else
    begin
      if (flitId == flitHeader)
        latchedLength <= length;  // Every header reloads the limit
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == latchedLength);

endmodule

// ==== src/outputArbiter.sv ====
`timescale 1ns/1ps

module outputArbiter (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   localReq,
  input  logic                   northReq,
  input  logic                   eastReq,
  input  logic                   westReq,
  input  logic                   southReq,
  input  routerPkg::flitId_t     localFlitId,
  input  routerPkg::flitId_t     northFlitId,
  input  routerPkg::flitId_t     eastFlitId,
  input  routerPkg::flitId_t     westFlitId,
  input  routerPkg::flitId_t     southFlitId,
  input  routerPkg::pktLength_t  localLength,
  input  routerPkg::pktLength_t  northLength,
  input  routerPkg::pktLength_t  eastLength,
  input  routerPkg::pktLength_t  westLength,
  input  routerPkg::pktLength_t  southLength,
  output routerPkg::arbState_t   grant
);

  import routerPkg::*;

  arbState_t  nextState;
  logic [4:0] reqVec;      // Bit order L, N, E, W, S
  logic [4:0] timesUpVec;
  logic [4:0] runTimer;
  logic [2:0] holdIdx;

  assign reqVec = {southReq, westReq, eastReq, northReq, localReq};

  // First requester at or after index first, in rotation L, N, E, W, S
  function automatic arbState_t pickPort(input logic [4:0] reqs, input int first);
    arbState_t pick;
    int        idx;
    pick = stIdle;
    for (int k = 4; k >= 0; k--)
    begin
      idx = (first + k) % 5;
      if (reqs[idx])
        pick = arbState_t'(6'b000010 << idx);  // Lowest k wins
    end
    return pick;
  endfunction

  grantTimer localTimer (
    .clk(clk), .rst(rst), .flitId(localFlitId), .length(localLength),
    .runTimer(runTimer[0]), .timesUp(timesUpVec[0])
  );

  grantTimer northTimer (
    .clk(clk), .rst(rst), .flitId(northFlitId), .length(northLength),
    .runTimer(runTimer[1]), .timesUp(timesUpVec[1])
  );

  grantTimer eastTimer (
    .clk(clk), .rst(rst), .flitId(eastFlitId), .length(eastLength),
    .runTimer(runTimer[2]), .timesUp(timesUpVec[2])
  );

  grantTimer westTimer (
    .clk(clk), .rst(rst), .flitId(westFlitId), .length(westLength),
    .runTimer(runTimer[3]), .timesUp(timesUpVec[3])
  );

  grantTimer southTimer (
    .clk(clk), .rst(rst), .flitId(southFlitId), .length(southLength),
    .runTimer(runTimer[4]), .timesUp(timesUpVec[4])
  );

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= stIdle;
    else
      grant <= nextState;
  end

  // Index of the current holder
  always_comb
  begin
    case (grant)
      stNorth: holdIdx = 3'd1;
      stEast:  holdIdx = 3'd2;
      stWest:  holdIdx = 3'd3;
      stSouth: holdIdx = 3'd4;
      default: holdIdx = 3'd0;
    endcase
  end

  always_comb
  begin
    runTimer  = '0;
    nextState = stIdle;
    case (grant)
      stIdle:
      begin
        nextState = pickPort(reqVec, 0);  // Fixed priority from idle
      end
      stLocal, stNorth, stEast, stWest, stSouth:
      begin
        if (reqVec[holdIdx] && !timesUpVec[holdIdx])
        begin
          runTimer[holdIdx] = 1'b1;
          nextState         = grant;
        end
        else
        begin
          // Holder sits out this decision
          nextState = pickPort(reqVec & ~(5'b00001 << holdIdx), int'(holdIdx) + 1);
        end
      end
      default:
      begin
        nextState = stIdle;
      end
    endcase
  end

endmodule

// ==== src/outputStage.sv ====
`timescale 1ns/1ps

module outputStage (
  input  logic                  clk,
  input  logic                  rst,
  input  routerPkg::arbState_t  grant,
  input  routerPkg::flit_t      localFlit,
  input  routerPkg::flit_t      northFlit,
  input  routerPkg::flit_t      eastFlit,
  input  routerPkg::flit_t      westFlit,
  input  routerPkg::flit_t      southFlit,
  input  logic                  localValid,
  input  logic                  northValid,
  input  logic                  eastValid,
  input  logic                  westValid,
  input  logic                  southValid,
  output routerPkg::flit_t      outFlit,
  output logic                  outValid,
  output routerPkg::arbState_t  outPort
);

  import routerPkg::*;

  flit_t selFlit;
  logic  selValid;

  always_comb
  begin
    case (grant)
      stLocal:
      begin
        selFlit  = localFlit;
        selValid = localValid;
      end
      stNorth:
      begin
        selFlit  = northFlit;
        selValid = northValid;
      end
      stEast:
      begin
        selFlit  = eastFlit;
        selValid = eastValid;
      end
      stWest:
      begin
        selFlit  = westFlit;
        selValid = westValid;
      end
      stSouth:
      begin
        selFlit  = southFlit;
        selValid = southValid;
      end
      default:
      begin
        selFlit  = '0;  // Idle
        selValid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outPort  <= stIdle;
    end
    else
    begin
      outValid <= selValid;
      outPort  <= grant;
    end
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
  end

endmodule

// ==== src/outputPortTop.sv ====
`timescale 1ns/1ps

module outputPortTop (
  input  logic                  clk,
  input  logic                  rst,
  input  routerPkg::flit_t      localFlit,
  input  routerPkg::flit_t      northFlit,
  input  routerPkg::flit_t      eastFlit,
  input  routerPkg::flit_t      westFlit,
  input  routerPkg::flit_t      southFlit,
  input  logic                  localValid,
  input  logic                  northValid,
  input  logic                  eastValid,
  input  logic                  westValid,
  input  logic                  southValid,
  output routerPkg::flit_t      outFlit,
  output logic                  outValid,
  output routerPkg::arbState_t  outPort
);

  import routerPkg::*;

  logic       localReq, northReq, eastReq, westReq, southReq;
  flitId_t    localId, northId, eastId, westId, southId;
  pktLength_t localLen, northLen, eastLen, westLen, southLen;
  flit_t      localAl, northAl, eastAl, westAl, southAl;  // Aligned with grant
  logic       localAv, northAv, eastAv, westAv, southAv;
  arbState_t  grant;

  flitDecoder localDec (
    .clk(clk), .rst(rst), .inFlit(localFlit), .inValid(localValid),
    .req(localReq), .flitId(localId), .length(localLen),
    .flitAligned(localAl), .validAligned(localAv)
  );

  flitDecoder northDec (
    .clk(clk), .rst(rst), .inFlit(northFlit), .inValid(northValid),
    .req(northReq), .flitId(northId), .length(northLen),
    .flitAligned(northAl), .validAligned(northAv)
  );

  flitDecoder eastDec (
    .clk(clk), .rst(rst), .inFlit(eastFlit), .inValid(eastValid),
    .req(eastReq), .flitId(eastId), .length(eastLen),
    .flitAligned(eastAl), .validAligned(eastAv)
  );

  flitDecoder westDec (
    .clk(clk), .rst(rst), .inFlit(westFlit), .inValid(westValid),
    .req(westReq), .flitId(westId), .length(westLen),
    .flitAligned(westAl), .validAligned(westAv)
  );

  flitDecoder southDec (
    .clk(clk), .rst(rst), .inFlit(southFlit), .inValid(southValid),
    .req(southReq), .flitId(southId), .length(southLen),
    .flitAligned(southAl), .validAligned(southAv)
  );

  outputArbiter arbiter (
    .clk(clk), .rst(rst),
    .localReq(localReq), .northReq(northReq), .eastReq(eastReq),
    .westReq(westReq), .southReq(southReq),
    .localFlitId(localId), .northFlitId(northId), .eastFlitId(eastId),
    .westFlitId(westId), .southFlitId(southId),
    .localLength(localLen), .northLength(northLen), .eastLength(eastLen),
    .westLength(westLen), .southLength(southLen),
    .grant(grant)
  );

  outputStage outStage (
    .clk(clk), .rst(rst), .grant(grant),
    .localFlit(localAl), .northFlit(northAl), .eastFlit(eastAl),
    .westFlit(westAl), .southFlit(southAl),
    .localValid(localAv), .northValid(northAv), .eastValid(eastAv),
    .westValid(westAv), .southValid(southAv),
    .outFlit(outFlit), .outValid(outValid), .outPort(outPort)
  );

endmodule

// ==== tests/outputPortTb.sv ====
`timescale 1ns/1ps

module outputPortTb;

  import routerPkg::*;

  localparam int drainCycles    = 8;
  localparam int idleCycles     = 10;
  localparam int singleCycles   = 20;
  localparam int priorityCycles = 22;
  localparam int rotateCycles   = 70;
  localparam int earlyCycles    = 30;
  localparam int randomCycles   = 210;
  localparam int totalCycles    = 5 + idleCycles + singleCycles + priorityCycles
                                  + rotateCycles + earlyCycles + randomCycles + 5 * drainCycles;

  logic       clk;
  logic       rst;
  flit_t      txFlit [5];  // Index order L, N, E, W, S
  logic [4:0] txValid;
  flit_t      outFlit;
  logic       outValid;
  arbState_t  outPort;
  string      testName;

  pktLength_t pktLen [5];   // Packet generator per port
  pktLength_t fixedLen [5];
  int         pktPos [5];
  logic [3:0] pktSeq [5];
  logic       randomLen;

  flit_t      h1Flit [5];   // Model of the stage 1 and aligned registers
  flit_t      h2Flit [5];
  logic [4:0] h1Valid;
  logic [4:0] h2Valid;
  pktLength_t mLimit [5];
  pktLength_t mCount [5];
  arbState_t  mGrant;
  arbState_t  expPort;
  flit_t      expFlit;
  logic       expValid;

  outputPortTop outputPortTop_inst (
    .clk(clk), .rst(rst),
    .localFlit(txFlit[0]), .northFlit(txFlit[1]), .eastFlit(txFlit[2]),
    .westFlit(txFlit[3]), .southFlit(txFlit[4]),
    .localValid(txValid[0]), .northValid(txValid[1]), .eastValid(txValid[2]),
    .westValid(txValid[3]), .southValid(txValid[4]),
    .outFlit(outFlit), .outValid(outValid), .outPort(outPort)
  );

  always
  begin
    #50 clk = ~clk;
  end

  function automatic arbState_t portOf(input int idx);
    case (idx)
      0: return stLocal;
      1: return stNorth;
      2: return stEast;
      3: return stWest;
      default: return stSouth;
    endcase
  endfunction

  function automatic int portIndex(input arbState_t state);
    for (int p = 0; p < 5; p++)
      if (portOf(p) == state)
        return p;
    return -1;  // Idle
  endfunction

  function automatic arbState_t nextInRotation(input arbState_t state);
    return portOf((portIndex(state) + 1) % 5);
  endfunction

  // Next requester after the holder in rotation or in L to S order from idle
  function automatic arbState_t firstAfter(input logic [4:0] reqs, input int hold);
    int idx;
    for (int k = 0; k < 5; k++)
    begin
      idx = (hold < 0) ? k : (hold + 1 + k) % 5;
      if (idx != hold && reqs[idx])
        return portOf(idx);
    end
    return stIdle;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
      $display("sim failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // Arbiter and pipeline model predicting the next output
  always @(posedge clk)
  begin
    int   hold;
    logic keep;
    hold = portIndex(mGrant);
    keep = 1'b0;
    if (hold >= 0)
      keep = h1Valid[hold] && (mCount[hold] != mLimit[hold]);
    for (int p = 0; p < 5; p++)
    begin
      h1Flit[p] <= txFlit[p];
      h2Flit[p] <= h1Flit[p];
    end
    if (rst)
    begin
      h1Valid  <= '0;
      h2Valid  <= '0;
      mGrant   <= stIdle;
      expPort  <= stIdle;
      expValid <= 1'b0;
      for (int p = 0; p < 5; p++)
      begin
        mLimit[p] <= '0;
        mCount[p] <= '0;
      end
    end
    else
    begin
      for (int p = 0; p < 5; p++)
      begin
        if (h1Flit[p][31:29] == flitHeader)
          mLimit[p] <= h1Flit[p][11:0];
        mCount[p] <= (keep && p == hold) ? mCount[p] + 1'b1 : '0;
      end
      mGrant   <= keep ? mGrant : firstAfter(h1Valid, hold);
      expPort  <= mGrant;
      expValid <= (hold >= 0) ? h2Valid[hold] : 1'b0;
      if (hold >= 0)
        expFlit <= h2Flit[hold];
      h1Valid <= txValid;
      h2Valid <= h1Valid;
    end
  end

  always @(negedge clk)
  begin
    if (!rst)
    begin
      checkValue({testName, " port"}, 32'(expPort), 32'(outPort));
      checkValue({testName, " valid"}, 32'(expValid), 32'(outValid));
      if (expValid)
        checkValue({testName, " flit"}, expFlit, outFlit);
    end
  end

  // Header carries the length with the tag in 28:16 and packet number in 15:12
  task automatic emitFlit(input int p);
    flitId_t kind;
    kind = flitBody;
    if (pktPos[p] == 0)
    begin
      pktLen[p] = randomLen ? pktLength_t'($urandom_range(6, 3)) : fixedLen[p];
      kind      = flitHeader;
    end
    else if (pktPos[p] == int'(pktLen[p]))
      kind = flitTail;
    txFlit[p] <= {kind, 13'(portOf(p)), pktSeq[p], (kind == flitHeader) ? pktLen[p] : 12'h0};
    if (kind == flitTail)
    begin
      pktPos[p] = 0;
      pktSeq[p] = pktSeq[p] + 1'b1;
    end
    else
      pktPos[p] = pktPos[p] + 1;
  endtask

  task automatic stepCycle(input logic [4:0] en);
    @(posedge clk);
    for (int p = 0; p < 5; p++)
    begin
      txValid[p] <= en[p];
      if (en[p])
        emitFlit(p);
    end
    @(negedge clk);  // Outputs settled here
  endtask

  task automatic drain();
    repeat (drainCycles) stepCycle('0);
    for (int p = 0; p < 5; p++)
      pktPos[p] = 0;
  endtask

  task automatic setLengths(input pktLength_t len);
    for (int p = 0; p < 5; p++)
      fixedLen[p] = len;
  endtask

  task automatic testIdle();
    testName = "idle";
    for (int i = 0; i < idleCycles; i++)
    begin
      stepCycle('0);
      checkValue(testName, 32'h0, 32'(outValid));
      checkValue(testName, 32'(stIdle), 32'(outPort));
    end
  endtask

  task automatic testSinglePort();
    int   westRun;
    logic runOver;
    testName = "single port";
    westRun  = 0;
    runOver  = 1'b0;
    setLengths(12'd4);
    for (int i = 0; i < singleCycles; i++)
    begin
      stepCycle((i < 8) ? 5'b01000 : 5'b00000);  // Valid held past the first packet
      if (!runOver)
      begin
        if (outPort == stWest)
          westRun++;
        else if (westRun > 0)
        begin
          runOver = 1'b1;
          checkValue("single port back to idle", 32'(stIdle), 32'(outPort));
        end
      end
    end
    checkValue("single port grant length", 32'd5, 32'(westRun));
    checkValue("single port idle at end", 32'(stIdle), 32'(outPort));
    drain();
  endtask

  task automatic testPriority();
    arbState_t first;
    testName = "priority";
    first    = stIdle;
    setLengths(12'd3);
    for (int i = 0; i < priorityCycles; i++)
    begin
      stepCycle(5'b10101);
      if (first == stIdle)
        first = outPort;
    end
    checkValue("priority first grant", 32'(stLocal), 32'(first));
    drain();
  endtask

  task automatic testRotation();
    arbState_t prev;
    arbState_t expNext;
    int        changes;
    testName = "rotation";
    prev     = stIdle;
    expNext  = stLocal;
    changes  = 0;
    setLengths(12'd2);
    for (int i = 0; i < rotateCycles; i++)
    begin
      stepCycle(5'b11111);
      if (outPort != prev)
      begin
        checkValue("rotation order", 32'(expNext), 32'(outPort));
        expNext = nextInRotation(expNext);
        changes++;
        prev = outPort;
      end
    end
    checkValue("rotation wrapped", 32'h1, 32'(changes >= 6));
    drain();
  endtask

  task automatic testEarlyRelease();
    arbState_t prev;
    int        westCycles;
    testName   = "early release";
    prev       = stIdle;
    westCycles = 0;
    setLengths(12'd10);
    for (int i = 0; i < earlyCycles; i++)
    begin
      stepCycle({1'b1, (i < 3), 3'b000});  // West stops after three flits
      if (outPort == stWest)
        westCycles++;
      if (prev == stWest && outPort != stWest)
        checkValue("early release next port", 32'(stSouth), 32'(outPort));
      prev = outPort;
    end
    checkValue("early release grant length", 32'd3, 32'(westCycles));
    drain();
  endtask

  task automatic testRandom();
    logic [3:0] lastSeq [5];
    logic [3:0] delta;
    int         idx;
    testName  = "random";
    randomLen = 1'b1;
    for (int p = 0; p < 5; p++)
    begin
      pktSeq[p]  = '0;
      lastSeq[p] = '0;
    end
    for (int i = 0; i < randomCycles; i++)
    begin
      stepCycle(5'($urandom));
      if (outValid)
      begin
        checkValue("random port tag", 32'(expPort), 32'(outFlit[28:16]));
        idx   = portIndex(expPort);
        delta = outFlit[15:12] - lastSeq[idx];  // 4 bit packet number wraps
        checkValue("random sequence order", 32'h1, 32'(delta < 4'd8));
        lastSeq[idx] = outFlit[15:12];
      end
    end
    randomLen = 1'b0;
    drain();
  endtask

  initial
  begin
    #(2.0 * 100.0 * totalCycles);
    $display("timeout, the tests did not finish within %0d cycles", 2 * totalCycles);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    void'($urandom(35));
    clk       = 1'b0;
    rst       = 1'b1;
    txValid   = '0;
    randomLen = 1'b0;
    testName  = "reset";
    for (int p = 0; p < 5; p++)
    begin
      txFlit[p]   = '0;
      pktLen[p]   = '0;
      fixedLen[p] = 12'd1;
      pktPos[p]   = 0;
      pktSeq[p]   = '0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    testIdle();
    testSinglePort();
    testPriority();
    testRotation();
    testEarlyRelease();
    testRandom();
    $display("sim passed");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+src
src/routerPkg.sv
src/flitDecoder.sv
src/grantTimer.sv
src/outputArbiter.sv
src/outputStage.sv
src/outputPortTop.sv
tests/outputPortTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= outputPortTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= sim passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
